/* rtl/umi_config.svh */
//===========================================================================
// build-time sizing for the UMI memory endpoint
// address width, data width, memory depth in words
//===========================================================================

`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

// request/response address bits
`define UMI_AW 32

// data word bits, one memory word per address word
`define UMI_DW 32

// words held by the endpoint, index wraps modulo this
`define MEM_DEPTH 256

`endif

/* rtl/umi_pkg.sv */
//===========================================================================
// UMI protocol types
// opcode union with write and atomic views, command word,
// request and response packets, write class and opcode constants
//===========================================================================

`include "umi_config.svh"

package umi_pkg;

   // opcode as seen by a write, class in the low 3 bits
   typedef struct packed {
      logic [3:0] rsvd;      // unused by writes
      logic       rd;        // 0 for all writes
      logic [2:0] wclass;    // normal/signal/stream/ack/response
   } umi_wr_view_t;

   // opcode as seen by a read or atomic
   typedef struct packed {
      logic       rsvd;
      logic [2:0] atype;     // swap..min, 111 unused
      logic       rd;        // 1 for reads and atomics
      logic [2:0] low;       // 001 marks an atomic
   } umi_at_view_t;

   // same byte, decoded per read bit
   typedef union packed {
      umi_wr_view_t wr;
      umi_at_view_t at;
   } umi_opcode_u;

   // command word, user on top, opcode in bits 7:0
   typedef struct packed {
      logic [19:0] user;     // passed through untouched
      logic [3:0]  size;     // burst length, carried not expanded
      umi_opcode_u opcode;
   } umi_cmd_t;

   // incoming request packet
   typedef struct packed {
      umi_cmd_t             cmd;
      logic [`UMI_AW-1:0]   addr;
      logic [`UMI_DW-1:0]   data;
   } umi_req_t;

   // outgoing response packet
   typedef struct packed {
      umi_cmd_t             cmd;   // RESP_OPCODE plus request size/user
      logic [`UMI_AW-1:0]   addr;  // request address echoed
      logic [`UMI_DW-1:0]   data;  // read word, old word, or zero
   } umi_resp_t;

   // write classes, one code each
   localparam logic [2:0] WR_NORMAL   = 3'b001;
   localparam logic [2:0] WR_SIGNAL   = 3'b010;
   localparam logic [2:0] WR_STREAM   = 3'b011;
   localparam logic [2:0] WR_ACK      = 3'b100;
   localparam logic [2:0] WR_RESPONSE = 3'b101;  // never accepted inbound

   // low code of a read-side opcode that selects an atomic
   localparam logic [2:0] AT_LOW_CODE = 3'b001;

   // atomic type code with no operation behind it
   localparam logic [2:0] AT_RESERVED = 3'b111;

   // opcode stamped on every response we send
   localparam logic [7:0] RESP_OPCODE = 8'h05;

endpackage

/* rtl/umi_mem_pkg.sv */
//===========================================================================
// execution-side types for the memory endpoint
// operation kind, atomic type, decoded operation struct
//===========================================================================

package umi_mem_pkg;

   // what the pipeline does with a request
   typedef enum logic [2:0] {
      OP_NONE,       // nothing decoded
      OP_WRITE,      // store, no response
      OP_WRITE_ACK,  // store, zero-data response
      OP_READ,       // return stored word
      OP_ATOMIC,     // return old word, store alu result
      OP_ERROR       // err pulse only
   } umi_op_kind_e;

   // atomic types, codes match the opcode atomic view
   typedef enum logic [2:0] {
      SWAP = 3'b000,
      ADD  = 3'b001,
      AND  = 3'b010,
      OR   = 3'b011,
      XOR  = 3'b100,
      MAX  = 3'b101,   // signed
      MIN  = 3'b110    // signed
   } umi_atype_e;

   // decoder output, 6 bits
   typedef struct packed {
      umi_op_kind_e kind;
      umi_atype_e   atype;   // only meaningful for OP_ATOMIC
   } umi_op_t;

endpackage

/* rtl/umi_decode.sv */
//===========================================================================
// UMI command decoder
// classifies the opcode byte into an operation kind and atomic type
//===========================================================================

`timescale 1ns/10ps

module umi_decode (
   input  umi_pkg::umi_cmd_t    cmd,  // packet command word
   output umi_mem_pkg::umi_op_t op    // decoded operation
);

   import umi_pkg::*;
   import umi_mem_pkg::*;

   umi_opcode_u opc;
   logic        is_zero;
   logic        is_read;

   assign opc     = cmd.opcode;
   assign is_zero = (opc == '0);   // all-zero opcode never valid
   assign is_read = opc.wr.rd;     // same bit in both views

   always_comb begin
      op.kind  = OP_NONE;
      op.atype = SWAP;

      if (is_zero) begin
         op.kind = OP_ERROR;
      end else if (!is_read) begin
         // write side, class picks the kind
         case (opc.wr.wclass)
            WR_NORMAL,
            WR_SIGNAL,
            WR_STREAM:   op.kind = OP_WRITE;
            WR_ACK:      op.kind = OP_WRITE_ACK;
            WR_RESPONSE: op.kind = OP_ERROR;   // we never take responses
            default:     op.kind = OP_ERROR;   // 000, 110, 111
         endcase
      end else if (opc.at.low == AT_LOW_CODE) begin
         // read-modify-write
         if (opc.at.atype == AT_RESERVED) begin
            op.kind = OP_ERROR;
         end else begin
            op.kind  = OP_ATOMIC;
            op.atype = umi_atype_e'(opc.at.atype);
         end
      end else begin
         op.kind = OP_READ;    // any other read-side low code
      end
   end

endmodule

/* rtl/umi_atomic_alu.sv */
//===========================================================================
// atomic read-modify-write arithmetic
// swap, add, and, or, xor, signed max, signed min
//===========================================================================

`timescale 1ns/10ps

`include "umi_config.svh"

module umi_atomic_alu (
   input  umi_mem_pkg::umi_atype_e atype,     // which atomic
   input  logic [`UMI_DW-1:0]      old_data,  // word currently in memory
   input  logic [`UMI_DW-1:0]      req_data,  // operand from request
   output logic [`UMI_DW-1:0]      new_data   // value written back
);

   import umi_mem_pkg::*;

   logic old_gt_req;   // signed compare shared by max/min

   assign old_gt_req = $signed(old_data) > $signed(req_data);

   always_comb begin
      case (atype)
         SWAP: new_data = req_data;
         ADD:  new_data = old_data + req_data;   // wraps
         AND:  new_data = old_data & req_data;
         OR:   new_data = old_data | req_data;
         XOR:  new_data = old_data ^ req_data;
         MAX:  new_data = old_gt_req ? old_data : req_data;
         MIN:  new_data = old_gt_req ? req_data : old_data;
         default: new_data = old_data;   // leave word alone
      endcase
   end

endmodule

/* rtl/umi_mem_ctrl.sv */
//===========================================================================
// two-stage execution pipeline for the UMI memory endpoint
// word memory, stage 1 capture with forwarding, writeback,
// response build, out_valid and err strobes
//===========================================================================

`timescale 1ns/10ps

`include "umi_config.svh"

module umi_mem_ctrl (
   input  logic                 clk,
   input  logic                 reset,      // sync, active high
   input  logic                 in_valid,   // one-cycle request strobe
   input  umi_pkg::umi_req_t    in_req,
   input  umi_mem_pkg::umi_op_t op,         // from decoder
   output logic                 out_valid,  // one-cycle response strobe
   output umi_pkg::umi_resp_t   out_resp,
   output logic                 err         // one-cycle error pulse
);

   import umi_pkg::*;
   import umi_mem_pkg::*;

   localparam int IW = $clog2(`MEM_DEPTH);   // memory index bits
   localparam int BW = $clog2(`UMI_DW / 8);  // byte offset within a word

   // word storage, contents survive reset
   logic [`UMI_DW-1:0] mem [`MEM_DEPTH];

   // stage 1 state
   logic               s1_valid;
   umi_op_t            s1_op;
   umi_req_t           s1_req;
   logic [`UMI_DW-1:0] s1_rdata;   // word before this request

   logic [IW-1:0]      in_idx;
   logic [IW-1:0]      s1_idx;
   logic               s1_wr;      // stage 1 commits to memory this edge
   logic               s1_resp;    // stage 1 owes a response
   logic [`UMI_DW-1:0] alu_data;
   logic [`UMI_DW-1:0] wr_data;
   logic [`UMI_DW-1:0] rd_word;    // memory word after forwarding

   // word index, wraps modulo depth
   assign in_idx = in_req.addr[BW +: IW];
   assign s1_idx = s1_req.addr[BW +: IW];

   umi_atomic_alu u_alu (
      .atype    (s1_op.atype),
      .old_data (s1_rdata),
      .req_data (s1_req.data),
      .new_data (alu_data)
   );

   assign s1_wr   = s1_valid &
                    (s1_op.kind inside {OP_WRITE, OP_WRITE_ACK, OP_ATOMIC});
   assign s1_resp = s1_valid &
                    (s1_op.kind inside {OP_READ, OP_ATOMIC, OP_WRITE_ACK});

   // atomics store the alu result, plain writes the request data
   assign wr_data = (s1_op.kind == OP_ATOMIC) ? alu_data : s1_req.data;

   // older request writes on the same edge we sample, so bypass it
   assign rd_word = (s1_wr && (s1_idx == in_idx)) ? wr_data : mem[in_idx];

   // stage 1 valid
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   // stage 1 payload, held while idle
   always_ff @(posedge clk) begin
      if (in_valid) begin
         s1_op    <= op;
         s1_req   <= in_req;
         s1_rdata <= rd_word;
      end
   end

   // writeback, one word per cycle
   always_ff @(posedge clk) begin
      if (s1_wr) begin
         mem[s1_idx] <= wr_data;
      end
   end

   // stage 2 strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         err       <= 1'b0;
      end else begin
         out_valid <= s1_resp;
         err       <= s1_valid & (s1_op.kind == OP_ERROR);
      end
   end

   // stage 2 response fields
   always_ff @(posedge clk) begin
      if (s1_resp) begin
         out_resp.cmd.opcode <= RESP_OPCODE;
         out_resp.cmd.size   <= s1_req.cmd.size;   // burst not expanded
         out_resp.cmd.user   <= s1_req.cmd.user;
         out_resp.addr       <= s1_req.addr;
         // ack carries no data, reads and atomics return the old word
         out_resp.data       <= (s1_op.kind == OP_WRITE_ACK) ? '0 : s1_rdata;
      end
   end

endmodule

/* rtl/umi_mem_top.sv */
//===========================================================================
// UMI memory endpoint top level
// command decoder feeding the execution pipeline
//===========================================================================

`timescale 1ns/10ps

module umi_mem_top (
   input  logic               clk,
   input  logic               reset,      // sync, active high
   input  logic               in_valid,   // request strobe
   input  umi_pkg::umi_req_t  in_req,
   output logic               out_valid,  // response strobe
   output umi_pkg::umi_resp_t out_resp,
   output logic               err         // bad command pulse
);

   import umi_mem_pkg::*;

   umi_op_t op;   // decoded, same cycle as in_req

   umi_decode u_decode (
      .cmd (in_req.cmd),
      .op  (op)
   );

   umi_mem_ctrl u_mem_ctrl (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .op        (op),
      .out_valid (out_valid),
      .out_resp  (out_resp),
      .err       (err)
   );

endmodule

/* tb/tb_umi_mem.sv */
//===========================================================================
// testbench for the UMI memory endpoint
// request/expected vectors from file, 2-cycle latency check queue,
// response field checks, idle check after reset, cycle timeout
//===========================================================================

`timescale 1ns/10ps

`include "umi_config.svh"

module tb_umi_mem;

   import umi_pkg::*;

   localparam logic [7:0] EXP_RESP_OPCODE = 8'h05;  // write-response opcode
   localparam int         RESET_CYCLES    = 10;
   localparam int         LATENCY         = 2;      // request edge to output edge

   // one stimulus line
   typedef struct packed {
      logic               valid;
      umi_req_t           req;
      logic               exp_valid;
      logic [`UMI_DW-1:0] exp_data;   // read word, old word, or zero for ack
      logic               exp_err;
   } vector_t;

   logic      clk = 1'b0;
   logic      reset;
   logic      in_valid;
   umi_req_t  in_req;
   logic      out_valid;
   umi_resp_t out_resp;
   logic      err;

   vector_t vectors[$];          // whole stimulus file
   vector_t pending[$];          // driven but response not yet due
   int      cycle_count = 0;
   int      cycle_limit = 1000;  // replaced once the file is loaded

   umi_mem_top uut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_resp  (out_resp),
      .err       (err)
   );

   always #5 clk = ~clk;   // 10 ns period

   // run limit counting rising edges
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Errors found");
         $fatal(1, "timeout: run went past %0d clock cycles", cycle_limit);
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
         $display("Errors found");
         $fatal(1, "wrong value on %s", name);
      end
   endtask

   // load tb/umi_stim.txt into the vector queue
   task automatic load_vectors();
      int          fd;
      int          code;
      string       line;
      logic [31:0] f_valid;
      logic [31:0] f_cmd;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_ev;
      logic [31:0] f_ed;
      logic [31:0] f_ee;
      vector_t     v;
      fd = $fopen("tb/umi_stim.txt", "r");
      if (fd == 0) begin
         $display("Errors found");
         $fatal(1, "could not open the stimulus file tb/umi_stim.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != 8'h23) begin  // skip '#' lines
               code = $sscanf(line, "%h %h %h %h %h %h %h",
                              f_valid, f_cmd, f_addr, f_data, f_ev, f_ed, f_ee);
               if (code != 7) begin
                  $display("Errors found");
                  $fatal(1, "stimulus line does not hold 7 fields: %s", line);
               end else begin
                  v.valid     = f_valid[0];
                  v.req.cmd   = f_cmd;      // user, size, opcode
                  v.req.addr  = f_addr;
                  v.req.data  = f_data;
                  v.exp_valid = f_ev[0];
                  v.exp_data  = f_ed;
                  v.exp_err   = f_ee[0];
                  vectors.push_back(v);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // outputs due for one earlier request
   task automatic compare_outputs(input vector_t v);
      check_value("out_valid", 32'(out_valid), 32'(v.exp_valid));
      check_value("err", 32'(err), 32'(v.exp_err));
      if (v.exp_valid) begin
         check_value("out_resp.data", out_resp.data, v.exp_data);
         check_value("out_resp.addr", out_resp.addr, v.req.addr);  // echoed
         check_value("out_resp.cmd.opcode", 32'(out_resp.cmd.opcode),
                     32'(EXP_RESP_OPCODE));
         check_value("out_resp.cmd.size", 32'(out_resp.cmd.size),
                     32'(v.req.cmd.size));
         check_value("out_resp.cmd.user", 32'(out_resp.cmd.user),
                     32'(v.req.cmd.user));
      end
   endtask

   initial begin
      vector_t cur;
      int      i;
      reset    = 1'b1;
      in_valid = 1'b1;   // request held on through reset
      in_req   = '0;     // all-zero opcode decodes as an error
      load_vectors();
      cycle_limit = vectors.size() + RESET_CYCLES + 20;

      repeat (RESET_CYCLES) @(negedge clk);
      reset    = 1'b0;
      in_valid = 1'b0;   // nothing from reset may reach the strobes

      // strobes quiet before the first request
      repeat (LATENCY) begin
         @(negedge clk);
         check_value("out_valid", 32'(out_valid), 32'd0);
         check_value("err", 32'(err), 32'd0);
      end

      // one request per cycle plus two cycles to drain the pipe
      for (i = 0; i < vectors.size() + LATENCY; i++) begin
         @(negedge clk);
         if (pending.size() == LATENCY) begin
            compare_outputs(pending.pop_front());
         end
         if (i < vectors.size()) begin
            cur = vectors[i];
         end else begin
            cur = '0;   // idle so nothing expected
         end
         in_valid = cur.valid;
         in_req   = cur.req;
         pending.push_back(cur);
      end

      $display("No errors");
      $finish;
   end

endmodule

/* sources.f */
+incdir+rtl
rtl/umi_pkg.sv
rtl/umi_mem_pkg.sv
rtl/umi_decode.sv
rtl/umi_atomic_alu.sv
rtl/umi_mem_ctrl.sv
rtl/umi_mem_top.sv
tb/tb_umi_mem.sv

/* run_sim.sh */
#!/bin/sh
# build the UMI memory endpoint and its testbench with Verilator, then run it
# exit status is nonzero if the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f sources.f \
   --top-module tb_umi_mem -o sim_umi_mem \
   && ./obj_dir/sim_umi_mem \
   || { echo "simulation failed"; exit 1; }

/* tb/umi_stim.txt */
# valid cmd addr data exp_valid exp_data exp_err, all hex, one request per clock
# cmd is user[31:12] size[11:8] opcode[7:0], response expected 2 cycles later
1 abcde101 00000100 11111111 0 00000000 0
1 abcde208 00000100 00000000 1 11111111 0
1 00010002 00000104 22222222 0 00000000 0
1 00020f08 00000104 00000000 1 22222222 0
1 00030103 00000108 33333333 0 00000000 0
1 00040108 00000108 00000000 1 33333333 0
1 fffff404 0000010c 44444444 1 00000000 0
0 00000000 00000000 00000000 0 00000000 0
1 1234500c 0000010c 00000000 1 44444444 0
1 00000001 00000200 0000000f 0 00000000 0
1 00100309 00000200 000000a5 1 0000000f 0
1 00000008 00000200 00000000 1 000000a5 0
1 00200019 00000200 ffffff60 1 000000a5 0
1 00000008 00000200 00000000 1 00000005 0
1 00300029 00000200 0000000c 1 00000005 0
1 00000008 00000200 00000000 1 00000004 0
1 00400039 00000200 00000030 1 00000004 0
1 00000008 00000200 00000000 1 00000034 0
1 00500049 00000200 000000ff 1 00000034 0
1 00000008 00000200 00000000 1 000000cb 0
1 00000002 00000200 fffffff0 0 00000000 0
1 00600059 00000200 00000003 1 fffffff0 0
1 00000008 00000200 00000000 1 00000003 0
1 00700069 00000200 80000000 1 00000003 0
1 00000008 00000200 00000000 1 80000000 0
1 00800059 00000200 fffffffe 1 80000000 0
1 00000008 00000200 00000000 1 fffffffe 0
1 00900069 00000200 7fffffff 1 fffffffe 0
1 00000008 00000200 00000000 1 fffffffe 0
0 00000000 00000000 00000000 0 00000000 0
1 00000003 00000300 00000010 0 00000000 0
1 0aaaa119 00000300 00000001 1 00000010 0
1 0bbbb119 00000300 00000001 1 00000011 0
1 0cccc149 00000300 00000003 1 00000012 0
1 00000008 00000300 00000000 1 00000011 0
1 00000000 00000300 deadbeef 0 00000000 1
1 00000005 00000300 deadbeef 0 00000000 1
1 00000010 00000300 deadbeef 0 00000000 1
1 00000006 00000300 deadbeef 0 00000000 1
1 00000007 00000300 deadbeef 0 00000000 1
1 00000079 00000300 deadbeef 0 00000000 1
1 00000008 00000300 00000000 1 00000011 0
1 00000001 00000400 5a5a5a5a 0 00000000 0
1 00000008 00000000 00000000 1 5a5a5a5a 0
0 00000000 00000000 00000000 0 00000000 0
